//--- verilog.f
+incdir+common
common/mipsIsaPkg.sv
common/mipsPipePkg.sv
logic/controlDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/hazardUnit.sv
core/fetchUnit.sv
core/mipsCore.sv
test/tbMipsCore.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the MIPS pipeline testbench with Verilator, runs it into sim.log and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module tbMipsCore -o simMipsCore \
    && ./obj_dir/simMipsCore > sim.log 2>&1

grep -qx "=== PASS ===" sim.log \
    && echo "Simulation passed, see sim.log" \
    || { cat sim.log 2>/dev/null; echo "Simulation failed, see sim.log"; exit 1; }

//--- test/tbMipsCore.sv
`default_nettype none
`include "mipsDefs.svh"

module tbMipsCore import mipsIsaPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // Random body, then r1..r31 stored to the dump area, then a j to itself
    localparam int bodyLen    = 48;
    localparam int progLen    = bodyLen + 32;
    localparam int dumpBase   = 64;
    localparam int cycleLimit = progLen * 12;

    logic                    clk;
    logic                    rst_n;
    logic                    icacheStall;
    logic                    dcacheStall;
    logic [`MIPS_ADDR_W-1:0] icacheAddr;
    logic [`MIPS_XLEN-1:0]   icacheRdata;
    logic                    dcacheRen;
    logic                    dcacheWen;
    logic [`MIPS_ADDR_W-1:0] dcacheAddr;
    logic [`MIPS_XLEN-1:0]   dcacheWdata;
    logic [`MIPS_XLEN-1:0]   dcacheRdata;

    logic [31:0] imem [128];
    logic [31:0] dmem [128];
    logic [31:0] modelMem [128];
    logic [31:0] modelRegs [32];
    logic [29:0] expAddr [$];
    logic [31:0] expData [$];
    logic [29:0] expLoad [$];
    integer      seed = 32'h89fe33bd;
    int          cycles = 0;
    int          resetEdges = 0;

    mipsCore i_dut (
        .clk(clk), .rst_n(rst_n),
        .icacheAddr(icacheAddr), .icacheStall(icacheStall), .icacheRdata(icacheRdata),
        .dcacheRen(dcacheRen), .dcacheWen(dcacheWen), .dcacheAddr(dcacheAddr),
        .dcacheWdata(dcacheWdata), .dcacheStall(dcacheStall), .dcacheRdata(dcacheRdata)
    );

    // Both caches answer within the cycle
    assign icacheRdata = imem[icacheAddr[6:0]];
    assign dcacheRdata = dmem[dcacheAddr[6:0]];

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED at time %0d ns: %s = 0x%08h, expected 0x%08h",
                               $time, name, got, exp));
        end
    endtask

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [4:0] pickReg();
        logic [31:0] v;
        v = $random(seed);
        // Low registers half the time so that hazards are common
        return v[3] ? v[8:4] : {2'b00, v[2:0]};
    endfunction

    function automatic funct_t pickFunct();
        case (randBelow(5))
            0: return fnAdd;
            1: return fnSub;
            2: return fnAnd;
            3: return fnOr;
            default: return fnSlt;
        endcase
    endfunction

    function automatic logic [31:0] encodeR(input funct_t fn, input logic [4:0] rd,
                                            input logic [4:0] rs, input logic [4:0] rt);
        return {opRtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(input opcode_t op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] fillWord(input int a);
        return (32'(a) * 32'h9e3779b1) ^ 32'hc3a50f1e;
    endfunction

    task automatic initMemories();
        for (int a = 0; a < 128; a++) begin
            imem[a]     = 32'd0;
            dmem[a]     = fillWord(a);
            modelMem[a] = fillWord(a);
        end
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = 32'd0;
        end
    endtask

    task automatic buildProgram();
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] lastDest;
        int         off;
        lastDest = 5'd0;
        for (int i = 0; i < bodyLen; i++) begin
            // Reuse the last result often so that loads feed the next instruction
            rs  = (randBelow(2) == 0) ? lastDest : pickReg();
            rt  = pickReg();
            rd  = pickReg();
            off = randBelow(4);
            if (off > bodyLen - 1 - i) begin
                off = bodyLen - 1 - i;
            end
            case (randBelow(10))
                0, 1, 2: begin
                    imem[i]  = encodeR(pickFunct(), rd, rs, rt);
                    lastDest = rd;
                end
                3, 4: begin
                    imem[i]  = encodeI(opAddi, rs, rt, 16'($random(seed)));
                    lastDest = rt;
                end
                5: begin
                    imem[i]  = encodeI(opLw, 5'd0, rt, 16'(randBelow(64) * 4));
                    lastDest = rt;
                end
                6: imem[i] = encodeI(opSw, 5'd0, rs, 16'(randBelow(64) * 4));
                7, 8: imem[i] = encodeI(opBeq, rs, rt, 16'(off));
                default: imem[i] = {opJ, 26'(i + 1 + off)};
            endcase
        end
        for (int r = 1; r < 32; r++) begin
            imem[bodyLen + r - 1] = encodeI(opSw, 5'd0, 5'(r), 16'((dumpBase + r) * 4));
        end
        imem[progLen - 1] = {opJ, 26'(progLen - 1)};
    endtask

    // Instruction-level reference model without a delay slot
    task automatic runModel();
        int          pc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] ea;
        logic [31:0] res;
        logic [4:0]  dest;
        pc = 0;
        while (pc != progLen - 1) begin
            instr = imem[pc];
            a     = modelRegs[instr[25:21]];
            b     = modelRegs[instr[20:16]];
            imm   = {{16{instr[15]}}, instr[15:0]};
            ea    = a + imm;
            res   = 32'd0;
            dest  = 5'd0;
            pc    = pc + 1;
            case (opcode_t'(instr[31:26]))
                opRtype: begin
                    dest = instr[15:11];
                    case (funct_t'(instr[5:0]))
                        fnSub:   res = a - b;
                        fnAnd:   res = a & b;
                        fnOr:    res = a | b;
                        fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: res = a + b;
                    endcase
                end
                opAddi: begin
                    dest = instr[20:16];
                    res  = ea;
                end
                opLw: begin
                    dest = instr[20:16];
                    res  = modelMem[ea[8:2]];
                    expLoad.push_back(ea[31:2]);
                end
                opSw: begin
                    modelMem[ea[8:2]] = b;
                    expAddr.push_back(ea[31:2]);
                    expData.push_back(b);
                end
                opBeq: begin
                    if (a == b) begin
                        pc = pc + int'(imm);
                    end
                end
                opJ: pc = int'(instr[25:0]);
                default: ;
            endcase
            if (dest != 5'd0) begin
                modelRegs[dest] = res;
            end
        end
    endtask

    task automatic commitStore();
        if (expAddr.size() == 0) begin
            abortRun($sformatf("Store to word 0x%08h after the last expected store",
                               32'(dcacheAddr)));
        end else begin
            compareValue("dcacheAddr", 32'(dcacheAddr), 32'(expAddr[0]));
            compareValue("dcacheWdata", dcacheWdata, expData[0]);
            void'(expAddr.pop_front());
            void'(expData.pop_front());
            dmem[dcacheAddr[6:0]] = dcacheWdata;
        end
    endtask

    task automatic commitLoad();
        if (expLoad.size() == 0) begin
            abortRun($sformatf("Load from word 0x%08h after the last expected load",
                               32'(dcacheAddr)));
        end else begin
            compareValue("dcacheAddr on load", 32'(dcacheAddr), 32'(expLoad[0]));
            void'(expLoad.pop_front());
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Each cache stalls about one cycle in four
    always @(posedge clk) begin
        icacheStall <= (randBelow(4) == 0);
        dcacheStall <= (randBelow(4) == 0);
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            // Outputs are defined once one reset edge has passed
            if (resetEdges > 0) begin
                compareValue("icacheAddr", 32'(icacheAddr), 32'd0);
                compareValue("dcacheRen", 32'(dcacheRen), 32'd0);
                compareValue("dcacheWen", 32'(dcacheWen), 32'd0);
            end
            resetEdges <= resetEdges + 1;
        end else begin
            if (cycles == 0) begin
                compareValue("icacheAddr", 32'(icacheAddr), 32'd0);
            end
            // No instruction reaches the memory stage before the fourth edge
            if (cycles < 3) begin
                compareValue("dcacheRen", 32'(dcacheRen), 32'd0);
                compareValue("dcacheWen", 32'(dcacheWen), 32'd0);
            end
            if (dcacheWen && !dcacheStall && !icacheStall) begin
                commitStore();
            end
            if (dcacheRen && !dcacheStall && !icacheStall) begin
                commitLoad();
            end
            if (cycles >= cycleLimit) begin
                abortRun($sformatf("Timeout: the program did not finish within %0d cycles",
                                   cycleLimit));
            end
            cycles <= cycles + 1;
        end
    end

    initial begin
        rst_n       = 1'b0;
        icacheStall = 1'b0;
        dcacheStall = 1'b0;
        initMemories();
        buildProgram();
        runModel();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        while (expAddr.size() != 0) begin
            @(posedge clk);
        end
        // Idle in the final loop to catch stores from squashed instructions
        repeat (20) @(posedge clk);
        compareValue("loads still expected", 32'(expLoad.size()), 32'd0);
        for (int r = 1; r < 32; r++) begin
            compareValue($sformatf("dump of r%0d", r), dmem[dumpBase + r], modelRegs[r]);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- core/mipsCore.sv
`default_nettype none
`include "mipsDefs.svh"

module mipsCore import mipsIsaPkg::*, mipsPipePkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [`MIPS_ADDR_W-1:0] icacheAddr,
    input  logic                    icacheStall,
    input  logic [`MIPS_XLEN-1:0]   icacheRdata,
    output logic                    dcacheRen,
    output logic                    dcacheWen,
    output logic [`MIPS_ADDR_W-1:0] dcacheAddr,
    output logic [`MIPS_XLEN-1:0]   dcacheWdata,
    input  logic                    dcacheStall,
    input  logic [`MIPS_XLEN-1:0]   dcacheRdata
);

    logic                   freeze;
    logic                   loadUse;
    flushReason_t           flushCause;
    fwdSel_t                fwdA;
    fwdSel_t                fwdB;

    // Decode stage
    logic [`MIPS_XLEN-1:0]  instrId;
    logic [`MIPS_XLEN-1:0]  pcPlus4Id;
    logic [`MIPS_XLEN-1:0]  immId;
    logic [`MIPS_XLEN-1:0]  jumpTarget;
    logic [`MIPS_XLEN-1:0]  rsValId;
    logic [`MIPS_XLEN-1:0]  rtValId;
    logic [`MIPS_REG_W-1:0] rsId;
    logic [`MIPS_REG_W-1:0] rtId;
    logic [`MIPS_REG_W-1:0] rdId;
    opcode_t                opcodeId;
    aluClass_t              aluClassId;
    logic regDstId, aluSrcId, memReadId, memWriteId;
    logic memToRegId, regWriteId, branchId, jumpId;

    // Execute stage
    aluClass_t              aluClassEx;
    logic regDstEx, aluSrcEx, memReadEx, memWriteEx;
    logic memToRegEx, regWriteEx, branchEx;
    logic [`MIPS_XLEN-1:0]  pcPlus4Ex;
    logic [`MIPS_XLEN-1:0]  rsValEx;
    logic [`MIPS_XLEN-1:0]  rtValEx;
    logic [`MIPS_XLEN-1:0]  immEx;
    logic [`MIPS_REG_W-1:0] rsEx;
    logic [`MIPS_REG_W-1:0] rtEx;
    logic [`MIPS_REG_W-1:0] rdEx;
    logic [`MIPS_XLEN-1:0]  opAEx;
    logic [`MIPS_XLEN-1:0]  rtFwdEx;
    logic [`MIPS_XLEN-1:0]  aluResultEx;
    logic                   zeroEx;

    // Memory and writeback stages
    logic memReadMem, memWriteMem, memToRegMem, regWriteMem, branchMem, zeroMem;
    logic [`MIPS_XLEN-1:0]  branchTargetMem;
    logic [`MIPS_XLEN-1:0]  aluResultMem;
    logic [`MIPS_XLEN-1:0]  storeDataMem;
    logic [`MIPS_REG_W-1:0] destMem;
    logic                   memToRegWb;
    logic                   regWriteWb;
    logic [`MIPS_XLEN-1:0]  loadDataWb;
    logic [`MIPS_XLEN-1:0]  aluResultWb;
    logic [`MIPS_REG_W-1:0] destWb;
    logic [`MIPS_XLEN-1:0]  wbData;

    function automatic logic [`MIPS_XLEN-1:0] operandMux(
        input fwdSel_t               sel,
        input logic [`MIPS_XLEN-1:0] regVal,
        input logic [`MIPS_XLEN-1:0] memVal,
        input logic [`MIPS_XLEN-1:0] wbVal
    );
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign freeze = icacheStall | dcacheStall;

    always_comb begin
        if (branchMem && zeroMem) begin
            flushCause = flushBranch;
        end else if (jumpId) begin
            flushCause = flushJump;
        end else begin
            flushCause = flushNone;
        end
    end

    fetchUnit u_fetch (
        .clk(clk), .rst_n(rst_n), .freeze(freeze), .hold(loadUse),
        .jumpTaken(flushCause == flushJump), .jumpTarget(jumpTarget),
        .branchTaken(flushCause == flushBranch), .branchTarget(branchTargetMem),
        .icacheAddr(icacheAddr), .icacheRdata(icacheRdata),
        .instrId(instrId), .pcPlus4Id(pcPlus4Id)
    );

    // Instruction fields
    assign opcodeId   = opcode_t'(instrId[31:26]);
    assign rsId       = instrId[25:21];
    assign rtId       = instrId[20:16];
    assign rdId       = instrId[15:11];
    assign immId      = {{(`MIPS_XLEN - `MIPS_IMM_W){instrId[`MIPS_IMM_W-1]}},
                         instrId[`MIPS_IMM_W-1:0]};
    assign jumpTarget = {pcPlus4Id[31:28], instrId[`MIPS_JTARGET_W-1:0], 2'b00};

    controlDecoder u_ctrl (
        .opcode(opcodeId), .bubble(loadUse),
        .regDst(regDstId), .aluSrc(aluSrcId), .memRead(memReadId),
        .memWrite(memWriteId), .memToReg(memToRegId), .regWrite(regWriteId),
        .branch(branchId), .jump(jumpId), .aluClass(aluClassId)
    );

    regFile u_regs (
        .clk(clk), .rst_n(rst_n),
        .writeEn(regWriteWb), .writeAddr(destWb), .writeData(wbData),
        .readAddrA(rsId), .readAddrB(rtId),
        .readDataA(rsValId), .readDataB(rtValId)
    );

    hazardUnit u_hazard (
        .memReadEx(memReadEx), .rtEx(rtEx), .rsId(rsId), .rtId(rtId), .rsEx(rsEx),
        .destMem(destMem), .regWriteMem(regWriteMem),
        .destWb(destWb), .regWriteWb(regWriteWb),
        .loadUse(loadUse), .fwdA(fwdA), .fwdB(fwdB)
    );

    // Decode/execute register, controls squashed by a taken branch
    always_ff @(posedge clk) begin
        if (!rst_n || (!freeze && flushCause == flushBranch)) begin
            {regDstEx, aluSrcEx, memReadEx, memWriteEx} <= '0;
            {memToRegEx, regWriteEx, branchEx} <= '0;
            aluClassEx <= clsMemAdd;
        end else if (!freeze) begin
            {regDstEx, aluSrcEx, memReadEx, memWriteEx} <=
                {regDstId, aluSrcId, memReadId, memWriteId};
            {memToRegEx, regWriteEx, branchEx} <= {memToRegId, regWriteId, branchId};
            aluClassEx <= aluClassId;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            pcPlus4Ex <= pcPlus4Id;
            rsValEx   <= rsValId;
            rtValEx   <= rtValId;
            immEx     <= immId;
            rsEx      <= rsId;
            rtEx      <= rtId;
            rdEx      <= rdId;
        end
    end

    // Store data takes the same forwarded value as operand B
    assign opAEx   = operandMux(fwdA, rsValEx, aluResultMem, wbData);
    assign rtFwdEx = operandMux(fwdB, rtValEx, aluResultMem, wbData);

    alu u_alu (
        .aluClass(aluClassEx), .funct(funct_t'(immEx[5:0])),
        .opA(opAEx), .opB(aluSrcEx ? immEx : rtFwdEx),
        .result(aluResultEx), .zero(zeroEx)
    );

    // Execute/memory register
    always_ff @(posedge clk) begin
        if (!rst_n || (!freeze && flushCause == flushBranch)) begin
            {memReadMem, memWriteMem, memToRegMem, regWriteMem, branchMem, zeroMem} <= '0;
        end else if (!freeze) begin
            {memReadMem, memWriteMem, memToRegMem} <= {memReadEx, memWriteEx, memToRegEx};
            {regWriteMem, branchMem, zeroMem} <= {regWriteEx, branchEx, zeroEx};
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            branchTargetMem <= pcPlus4Ex + {immEx[`MIPS_XLEN-3:0], 2'b00};
            aluResultMem    <= aluResultEx;
            storeDataMem    <= rtFwdEx;
            destMem         <= regDstEx ? rdEx : rtEx;
        end
    end

    assign dcacheRen   = memReadMem;
    assign dcacheWen   = memWriteMem;
    assign dcacheAddr  = aluResultMem[`MIPS_XLEN-1:2];
    assign dcacheWdata = storeDataMem;

    // Memory/writeback register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            memToRegWb <= 1'b0;
            regWriteWb <= 1'b0;
        end else if (!freeze) begin
            memToRegWb <= memToRegMem;
            regWriteWb <= regWriteMem;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            loadDataWb  <= dcacheRdata;
            aluResultWb <= aluResultMem;
            destWb      <= destMem;
        end
    end

    assign wbData = memToRegWb ? loadDataWb : aluResultWb;

    strobeExclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcacheRen && dcacheWen));

    // A strobe only rises when a memory op advanced out of execute
    strobeSource: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dcacheRen || dcacheWen) |-> $past(memReadEx || memWriteEx));

endmodule

`default_nettype wire

//--- core/fetchUnit.sv
`default_nettype none
`include "mipsDefs.svh"

module fetchUnit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    freeze,
    input  logic                    hold,
    input  logic                    jumpTaken,
    input  logic [`MIPS_XLEN-1:0]   jumpTarget,
    input  logic                    branchTaken,
    input  logic [`MIPS_XLEN-1:0]   branchTarget,
    output logic [`MIPS_ADDR_W-1:0] icacheAddr,
    input  logic [`MIPS_XLEN-1:0]   icacheRdata,
    output logic [`MIPS_XLEN-1:0]   instrId,
    output logic [`MIPS_XLEN-1:0]   pcPlus4Id
);

    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] pcPlus4;
    logic [`MIPS_XLEN-1:0] pcNext;

    assign pcPlus4    = pc + 'd4;
    assign icacheAddr = pc[`MIPS_XLEN-1:2];

    // Branch from memory stage is older than a jump in decode
    always_comb begin
        if (branchTaken) begin
            pcNext = branchTarget;
        end else if (jumpTaken) begin
            pcNext = jumpTarget;
        end else if (hold) begin
            pcNext = pc;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= '0;
            instrId   <= '0;
            pcPlus4Id <= '0;
        end else if (!freeze) begin
            pc <= pcNext;
            if (branchTaken || jumpTaken) begin
                // Squash the fetched word to a no-op
                instrId <= '0;
            end else if (!hold) begin
                instrId   <= icacheRdata;
                pcPlus4Id <= pcPlus4;
            end
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- logic/hazardUnit.sv
`default_nettype none
`include "mipsDefs.svh"

module hazardUnit import mipsPipePkg::*; (
    input  logic                   memReadEx,
    input  logic [`MIPS_REG_W-1:0] rtEx,
    input  logic [`MIPS_REG_W-1:0] rsId,
    input  logic [`MIPS_REG_W-1:0] rtId,
    input  logic [`MIPS_REG_W-1:0] rsEx,
    input  logic [`MIPS_REG_W-1:0] destMem,
    input  logic                   regWriteMem,
    input  logic [`MIPS_REG_W-1:0] destWb,
    input  logic                   regWriteWb,
    output logic                   loadUse,
    output fwdSel_t                fwdA,
    output fwdSel_t                fwdB
);

    // Youngest producer wins, r0 is never a real destination
    function automatic fwdSel_t pickSource(
        input logic [`MIPS_REG_W-1:0] src,
        input logic [`MIPS_REG_W-1:0] memDest,
        input logic                   memWe,
        input logic [`MIPS_REG_W-1:0] wbDest,
        input logic                   wbWe
    );
        if (memWe && memDest != '0 && memDest == src) begin
            return fwdMem;
        end else if (wbWe && wbDest != '0 && wbDest == src) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign fwdA = pickSource(rsEx, destMem, regWriteMem, destWb, regWriteWb);
    assign fwdB = pickSource(rtEx, destMem, regWriteMem, destWb, regWriteWb);

    // Load result is not ready until after the memory stage
    assign loadUse = memReadEx && (rtEx != '0) && ((rtEx == rsId) || (rtEx == rtId));

endmodule

`default_nettype wire

//--- logic/alu.sv
`default_nettype none
`include "mipsDefs.svh"

module alu import mipsIsaPkg::*; (
    input  aluClass_t             aluClass,
    input  funct_t                funct,
    input  logic [`MIPS_XLEN-1:0] opA,
    input  logic [`MIPS_XLEN-1:0] opB,
    output logic [`MIPS_XLEN-1:0] result,
    output logic                  zero
);

    aluOp_t op;
    logic   lessThan;

    // Loads, stores and addi add, beq subtracts
    always_comb begin
        case (aluClass)
            clsBranchSub: op = aluSub;
            clsFunct: begin
                case (funct)
                    fnSub:   op = aluSub;
                    fnAnd:   op = aluAnd;
                    fnOr:    op = aluOr;
                    fnSlt:   op = aluSlt;
                    default: op = aluAdd;
                endcase
            end
            default: op = aluAdd;
        endcase
    end

    assign lessThan = $signed(opA) < $signed(opB);

    always_comb begin
        case (op)
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluSlt:  result = {{(`MIPS_XLEN - 1){1'b0}}, lessThan};
            default: result = opA + opB;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- logic/regFile.sv
`default_nettype none
`include "mipsDefs.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   writeEn,
    input  logic [`MIPS_REG_W-1:0] writeAddr,
    input  logic [`MIPS_XLEN-1:0]  writeData,
    input  logic [`MIPS_REG_W-1:0] readAddrA,
    input  logic [`MIPS_REG_W-1:0] readAddrB,
    output logic [`MIPS_XLEN-1:0]  readDataA,
    output logic [`MIPS_XLEN-1:0]  readDataB
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

    // Same-cycle write is visible to the reader
    function automatic logic [`MIPS_XLEN-1:0] readPort(input logic [`MIPS_REG_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (writeEn && writeAddr == addr) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    always_comb begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

    zeroReg: assert property (@(posedge clk) (readAddrA == '0) |-> (readDataA == '0));

endmodule

`default_nettype wire

//--- logic/controlDecoder.sv
`default_nettype none

module controlDecoder import mipsIsaPkg::*; (
    input  opcode_t   opcode,
    input  logic      bubble,
    output logic      regDst,
    output logic      aluSrc,
    output logic      memRead,
    output logic      memWrite,
    output logic      memToReg,
    output logic      regWrite,
    output logic      branch,
    output logic      jump,
    output aluClass_t aluClass
);

    always_comb begin
        regDst   = 1'b0;
        aluSrc   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        regWrite = 1'b0;
        branch   = 1'b0;
        jump     = 1'b0;
        aluClass = clsMemAdd;

        // Bubble leaves everything inactive
        if (!bubble) begin
            case (opcode)
                opRtype: begin
                    regDst   = 1'b1;
                    regWrite = 1'b1;
                    aluClass = clsFunct;
                end
                opAddi: begin
                    aluSrc   = 1'b1;
                    regWrite = 1'b1;
                end
                opLw: begin
                    aluSrc   = 1'b1;
                    memRead  = 1'b1;
                    memToReg = 1'b1;
                    regWrite = 1'b1;
                end
                opSw: begin
                    aluSrc   = 1'b1;
                    memWrite = 1'b1;
                end
                opBeq: begin
                    branch   = 1'b1;
                    aluClass = clsBranchSub;
                end
                opJ: begin
                    jump = 1'b1;
                end
                // Anything else runs as a no-op
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- common/mipsPipePkg.sv
`default_nettype none

package mipsPipePkg;

    // Source of an execute-stage operand
    typedef enum logic [1:0] {
        fwdReg = 2'd0,
        fwdMem = 2'd1,
        fwdWb  = 2'd2
    } fwdSel_t;

    // Why younger stages get squashed this cycle
    // Branch outranks jump since it is the older instruction
    typedef enum logic [1:0] {
        flushNone   = 2'd0,
        flushJump   = 2'd1,
        flushBranch = 2'd2
    } flushReason_t;

endpackage

`default_nettype wire

//--- common/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcode_t;

    // Function field of R-type, bits 5:0
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } funct_t;

    // Operation actually carried out by the ALU
    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluSlt = 4'd4
    } aluOp_t;

    // What decode requests from the ALU
    typedef enum logic [1:0] {
        clsMemAdd    = 2'd0,
        clsBranchSub = 2'd1,
        clsFunct     = 2'd2
    } aluClass_t;

endpackage

`default_nettype wire

//--- common/mipsDefs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Data path and program counter width
`define MIPS_XLEN 32

// Word address presented to both caches
`define MIPS_ADDR_W 30

// Register index and register count
`define MIPS_REG_W 5
`define MIPS_NUM_REGS 32

// Immediate field of I-type instructions
`define MIPS_IMM_W 16

// Target field of j
`define MIPS_JTARGET_W 26

`endif
